// ==== common/tcdm_pkg.sv ====
// TCDM cluster package.
// Shared sizing, address slicing and opcode encoding for the
// four-port, four-bank word-interleaved data memory.

package tcdm_pkg;

  // --------------------------------------------------
  // Cluster sizing
  // --------------------------------------------------

  // Requester ports into the interconnect.
  localparam int unsigned NUM_PORTS = 4;
  // Single-cycle SRAM banks behind the interconnect.
  localparam int unsigned NUM_BANKS = 4;
  // Width of a port index, used by the arbiters.
  localparam int unsigned PORT_IDX_WIDTH = $clog2(NUM_PORTS);

  // Requester byte address.
  localparam int unsigned ADDR_WIDTH = 32;
  // One data word.
  localparam int unsigned DATA_WIDTH = 32;
  // One strobe per data byte.
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // --------------------------------------------------
  // Address slicing
  // --------------------------------------------------

  // Byte offset inside a word, never routed.
  localparam int unsigned BYTE_OFFSET = $clog2(STRB_WIDTH);
  // Bank select sits right above the byte offset.
  localparam int unsigned SEL_WIDTH = $clog2(NUM_BANKS);
  // Words held in one bank.
  localparam int unsigned BANK_WORDS = 64;
  // Bank-local word address, right above the select bits.
  localparam int unsigned MEM_ADDR_WIDTH = $clog2(BANK_WORDS);
  // LSB of the bank-local address inside the byte address.
  localparam int unsigned MEM_ADDR_LSB = BYTE_OFFSET + SEL_WIDTH;

  // Cycles from request handshake to response valid.
  localparam int unsigned RSP_LATENCY = 1;

  // --------------------------------------------------
  // Request opcode
  // --------------------------------------------------

  // Writes also return the old word on the response.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } tcdm_op_e;

endpackage

// ==== common/tcdm_bus_if.sv ====
// TCDM bus interface.
// One request/response channel: valid/ready request, fixed-latency response.

interface tcdm_bus_if
  import tcdm_pkg::*;
#(
  // Byte address on the port side, word address on the bank side.
  parameter int unsigned ADDR_W = ADDR_WIDTH
) ();

  // Request channel.
  logic                  q_valid;
  logic                  q_ready;
  logic [ADDR_W-1:0]     addr;
  tcdm_op_e              op;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] strb;

  // Response channel, no handshake.
  logic                  p_valid;
  logic [DATA_WIDTH-1:0] rdata;

  // Side that issues requests.
  modport requester (output q_valid, addr, op, wdata, strb, input q_ready, p_valid, rdata);
  // Side that serves requests.
  modport responder (input q_valid, addr, op, wdata, strb, output q_ready, p_valid, rdata);

endinterface

// ==== rtl/tcdm_bank.sv ====
// TCDM SRAM bank.
// Always ready, byte-strobed writes, registered read-before-write response.

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  tcdm_bus_if.responder mem_bus
);

  logic [DATA_WIDTH-1:0] mem_q [BANK_WORDS];
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  p_valid_q;

  // No conflicts at the bank itself.
  assign mem_bus.q_ready = 1'b1;

  // Response flag follows the transfer by one cycle.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      p_valid_q <= 1'b0;
    end else begin
      p_valid_q <= mem_bus.q_valid;
    end
  end

  // Old word goes out, strobed bytes come in.
  always_ff @(posedge clk_i) begin
    if (mem_bus.q_valid) begin
      rdata_q <= mem_q[mem_bus.addr];
      if (mem_bus.op == OP_WRITE) begin
        for (int unsigned i = 0; i < STRB_WIDTH; i++) begin
          if (mem_bus.strb[i]) mem_q[mem_bus.addr][8*i +: 8] <= mem_bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign mem_bus.p_valid = p_valid_q;
  assign mem_bus.rdata   = rdata_q;

endmodule

// ==== tcdm_interconnect/tcdm_rsp_tracker.sv ====
// TCDM response tracker.
// Delays one port's grant record by the bank latency and picks
// the granted bank's response.

module tcdm_rsp_tracker
  import tcdm_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 grant_i,
  input  logic [SEL_WIDTH-1:0]                 sel_i,
  input  logic [NUM_BANKS-1:0]                 bank_p_valid_i,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata_i,
  output logic                                 p_valid_o,
  output logic [DATA_WIDTH-1:0]                rdata_o
);

  // Stage 0 of the record chain holds the youngest grant.
  logic [RSP_LATENCY-1:0]                vld_q;
  logic [RSP_LATENCY-1:0][SEL_WIDTH-1:0] sel_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= RSP_LATENCY'({vld_q, grant_i});
    end
  end

  // Granted bank select moves along with the valid flag.
  always_ff @(posedge clk_i) begin
    sel_q <= (RSP_LATENCY * SEL_WIDTH)'({sel_q, sel_i});
  end

  // Bank answers in the same cycle the record comes out.
  assign p_valid_o = vld_q[RSP_LATENCY-1] && bank_p_valid_i[sel_q[RSP_LATENCY-1]];
  assign rdata_o   = bank_rdata_i[sel_q[RSP_LATENCY-1]];

endmodule

// ==== tcdm_interconnect/tcdm_xbar_arb.sv ====
// TCDM request crossbar.
// One round-robin arbiter per bank, a lock-in of a waiting winner,
// and a combinational payload path from port to bank.

module tcdm_xbar_arb
  import tcdm_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic     [NUM_PORTS-1:0]                   in_valid_i,
  output logic     [NUM_PORTS-1:0]                   in_ready_o,
  input  logic     [NUM_PORTS-1:0][SEL_WIDTH-1:0]    in_sel_i,
  input  logic     [NUM_PORTS-1:0][MEM_ADDR_WIDTH-1:0] in_addr_i,
  input  tcdm_op_e [NUM_PORTS-1:0]                   in_op_i,
  input  logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0]   in_wdata_i,
  input  logic     [NUM_PORTS-1:0][STRB_WIDTH-1:0]   in_strb_i,
  output logic     [NUM_BANKS-1:0]                   out_valid_o,
  input  logic     [NUM_BANKS-1:0]                   out_ready_i,
  output logic     [NUM_BANKS-1:0][MEM_ADDR_WIDTH-1:0] out_addr_o,
  output tcdm_op_e [NUM_BANKS-1:0]                   out_op_o,
  output logic     [NUM_BANKS-1:0][DATA_WIDTH-1:0]   out_wdata_o,
  output logic     [NUM_BANKS-1:0][STRB_WIDTH-1:0]   out_strb_o
);

  // Winner index and handshake per bank, used to build the readies.
  logic [NUM_BANKS-1:0][PORT_IDX_WIDTH-1:0] winner;
  logic [NUM_BANKS-1:0]                     bank_fire;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_arb
    logic [NUM_PORTS-1:0]      req;
    logic [PORT_IDX_WIDTH-1:0] rr_q;
    logic [PORT_IDX_WIDTH-1:0] rr_idx;
    logic [PORT_IDX_WIDTH-1:0] win_idx;
    logic [PORT_IDX_WIDTH-1:0] lock_idx_q;
    logic                      lock_q;

    // Ports whose select points at this bank.
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_req
      assign req[p] = in_valid_i[p] && (in_sel_i[p] == SEL_WIDTH'(b));
    end

    // First requester at or after the pointer.
    always_comb begin : rr_pick
      logic                      found;
      logic [PORT_IDX_WIDTH-1:0] idx;
      found  = 1'b0;
      rr_idx = rr_q;
      for (int unsigned k = 0; k < NUM_PORTS; k++) begin
        idx = PORT_IDX_WIDTH'((rr_q + k) % NUM_PORTS);
        if (!found && req[idx]) begin
          found  = 1'b1;
          rr_idx = idx;
        end
      end
    end

    // A waiting winner keeps the bank until it transfers.
    assign win_idx      = lock_q ? lock_idx_q : rr_idx;
    assign out_valid_o[b] = |req;
    assign bank_fire[b] = out_valid_o[b] && out_ready_i[b];
    assign winner[b]    = win_idx;

    // Winner payload to the bank.
    assign out_addr_o[b]  = in_addr_i[win_idx];
    assign out_op_o[b]    = in_op_i[win_idx];
    assign out_wdata_o[b] = in_wdata_i[win_idx];
    assign out_strb_o[b]  = in_strb_i[win_idx];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rr_q       <= '0;
        lock_q     <= 1'b0;
        lock_idx_q <= '0;
      end else begin
        // Lock only while the bank stalls the winner.
        lock_q     <= out_valid_o[b] && !out_ready_i[b];
        lock_idx_q <= win_idx;
        // Pointer moves one past the winner.
        if (bank_fire[b]) begin
          rr_q <= (win_idx == PORT_IDX_WIDTH'(NUM_PORTS - 1)) ? '0 : win_idx + 1'b1;
        end
      end
    end
  end

  // Ready goes back only to the winner of a bank that accepted.
  always_comb begin
    in_ready_o = '0;
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      if (bank_fire[b]) begin
        in_ready_o[winner[b]] = 1'b1;
      end
    end
  end

endmodule

// ==== tcdm_interconnect/tcdm_interconnect.sv ====
// TCDM interconnect.
// Slices port addresses into bank select and bank-local address, arbitrates
// bank conflicts in the crossbar and routes fixed-latency responses back.

module tcdm_interconnect
  import tcdm_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  tcdm_bus_if.responder port_bus [NUM_PORTS-1:0],
  tcdm_bus_if.requester bank_bus [NUM_BANKS-1:0]
);

  // Flattened port side.
  logic     [NUM_PORTS-1:0]                     in_valid;
  logic     [NUM_PORTS-1:0]                     in_ready;
  logic     [NUM_PORTS-1:0][SEL_WIDTH-1:0]      in_sel;
  logic     [NUM_PORTS-1:0][MEM_ADDR_WIDTH-1:0] in_addr;
  tcdm_op_e [NUM_PORTS-1:0]                     in_op;
  logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0]     in_wdata;
  logic     [NUM_PORTS-1:0][STRB_WIDTH-1:0]     in_strb;

  // Flattened bank side.
  logic     [NUM_BANKS-1:0]                     out_valid;
  logic     [NUM_BANKS-1:0]                     out_ready;
  logic     [NUM_BANKS-1:0][MEM_ADDR_WIDTH-1:0] out_addr;
  tcdm_op_e [NUM_BANKS-1:0]                     out_op;
  logic     [NUM_BANKS-1:0][DATA_WIDTH-1:0]     out_wdata;
  logic     [NUM_BANKS-1:0][STRB_WIDTH-1:0]     out_strb;
  logic     [NUM_BANKS-1:0]                     bank_p_valid;
  logic     [NUM_BANKS-1:0][DATA_WIDTH-1:0]     bank_rdata;

  // --------------------------------------------------
  // Port side: address slicing and responses
  // --------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    logic                  rsp_valid;
    logic [DATA_WIDTH-1:0] rsp_rdata;

    // Word-interleaved, upper address bits are dropped.
    assign in_valid[p] = port_bus[p].q_valid;
    assign in_sel[p]   = port_bus[p].addr[BYTE_OFFSET +: SEL_WIDTH];
    assign in_addr[p]  = port_bus[p].addr[MEM_ADDR_LSB +: MEM_ADDR_WIDTH];
    assign in_op[p]    = port_bus[p].op;
    assign in_wdata[p] = port_bus[p].wdata;
    assign in_strb[p]  = port_bus[p].strb;
    assign port_bus[p].q_ready = in_ready[p];

    // Grant record follows the handshake, select picks the bank later.
    tcdm_rsp_tracker i_rsp_tracker (
      .clk_i,
      .arst_n_i,
      .grant_i        ( in_valid[p] & in_ready[p] ),
      .sel_i          ( in_sel[p]                 ),
      .bank_p_valid_i ( bank_p_valid              ),
      .bank_rdata_i   ( bank_rdata                ),
      .p_valid_o      ( rsp_valid                 ),
      .rdata_o        ( rsp_rdata                 )
    );

    assign port_bus[p].p_valid = rsp_valid;
    assign port_bus[p].rdata   = rsp_rdata;
  end

  // --------------------------------------------------
  // Bank side
  // --------------------------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    assign bank_bus[b].q_valid = out_valid[b];
    assign bank_bus[b].addr    = out_addr[b];
    assign bank_bus[b].op      = out_op[b];
    assign bank_bus[b].wdata   = out_wdata[b];
    assign bank_bus[b].strb    = out_strb[b];
    assign out_ready[b]        = bank_bus[b].q_ready;
    // All bank responses, trackers choose.
    assign bank_p_valid[b]     = bank_bus[b].p_valid;
    assign bank_rdata[b]       = bank_bus[b].rdata;
  end

  // Request crossbar.
  tcdm_xbar_arb i_xbar_arb (
    .clk_i,
    .arst_n_i,
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .in_sel_i    ( in_sel    ),
    .in_addr_i   ( in_addr   ),
    .in_op_i     ( in_op     ),
    .in_wdata_i  ( in_wdata  ),
    .in_strb_i   ( in_strb   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .out_addr_o  ( out_addr  ),
    .out_op_o    ( out_op    ),
    .out_wdata_o ( out_wdata ),
    .out_strb_o  ( out_strb  )
  );

endmodule

// ==== rtl/tcdm_cluster_top.sv ====
// TCDM cluster top level.
// Four requester ports on plain arrays, the interconnect, four banks.

module tcdm_cluster_top
  import tcdm_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic     [NUM_PORTS-1:0]                 req_valid_i,
  output logic     [NUM_PORTS-1:0]                 req_ready_o,
  input  logic     [NUM_PORTS-1:0][ADDR_WIDTH-1:0] req_addr_i,
  input  tcdm_op_e [NUM_PORTS-1:0]                 req_op_i,
  input  logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0] req_wdata_i,
  input  logic     [NUM_PORTS-1:0][STRB_WIDTH-1:0] req_strb_i,
  output logic     [NUM_PORTS-1:0]                 rsp_valid_o,
  output logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0] rsp_rdata_o
);

  // Port side carries byte addresses, bank side word addresses.
  tcdm_bus_if                                 port_bus [NUM_PORTS-1:0] ();
  tcdm_bus_if #(.ADDR_W(MEM_ADDR_WIDTH)) bank_bus [NUM_BANKS-1:0] ();

  // --------------------------------------------------
  // Plain ports onto the channel bundles
  // --------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    assign port_bus[p].q_valid = req_valid_i[p];
    assign port_bus[p].addr    = req_addr_i[p];
    assign port_bus[p].op      = req_op_i[p];
    assign port_bus[p].wdata   = req_wdata_i[p];
    assign port_bus[p].strb    = req_strb_i[p];
    assign req_ready_o[p]      = port_bus[p].q_ready;
    assign rsp_valid_o[p]      = port_bus[p].p_valid;
    assign rsp_rdata_o[p]      = port_bus[p].rdata;
  end

  tcdm_interconnect i_interconnect (
    .clk_i,
    .arst_n_i,
    .port_bus ( port_bus ),
    .bank_bus ( bank_bus )
  );

  // One SRAM per interleaved word slot.
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i,
      .arst_n_i,
      .mem_bus ( bank_bus[b] )
    );
  end

endmodule

// ==== verification/tb_tcdm_cluster_top.sv ====
// TCDM cluster testbench.
// Drives the four ports with directed and random traffic and checks every
// response, ready and arbitration bound against a reference memory model.

module tb_tcdm_cluster_top;
  import tcdm_pkg::*;

  localparam int unsigned SEED    = 32'hbd87_bcf9;
  localparam int unsigned MAX_REQ = 128;
  // Requests issued over the fill, strobe, conflict, interleave and random tests.
  localparam int unsigned TOTAL_REQ   = 256 + 12 + 32 + 32 + 400;
  localparam int unsigned CYCLE_LIMIT = 4 * TOTAL_REQ + 200;

  logic                                 clk_i = 1'b0;
  logic                                 arst_n_i;
  logic     [NUM_PORTS-1:0]                 req_valid_i;
  logic     [NUM_PORTS-1:0]                 req_ready_o;
  logic     [NUM_PORTS-1:0][ADDR_WIDTH-1:0] req_addr_i;
  tcdm_op_e [NUM_PORTS-1:0]                 req_op_i;
  logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0] req_wdata_i;
  logic     [NUM_PORTS-1:0][STRB_WIDTH-1:0] req_strb_i;
  logic     [NUM_PORTS-1:0]                 rsp_valid_o;
  logic     [NUM_PORTS-1:0][DATA_WIDTH-1:0] rsp_rdata_o;

  // Reference memory with a flag per word that is set once fully written.
  logic [DATA_WIDTH-1:0] model_mem   [NUM_BANKS][BANK_WORDS];
  bit                    model_known [NUM_BANKS][BANK_WORDS];

  // One response slot per port for the single-cycle latency.
  bit                    pend_vld [NUM_PORTS];
  bit                    pend_chk [NUM_PORTS];
  logic [DATA_WIDTH-1:0] pend_data [NUM_PORTS];
  int unsigned           wait_cnt [NUM_PORTS];

  // Per-port request lists for the running test.
  logic [ADDR_WIDTH-1:0] rq_addr  [NUM_PORTS][MAX_REQ];
  tcdm_op_e              rq_op    [NUM_PORTS][MAX_REQ];
  logic [DATA_WIDTH-1:0] rq_wdata [NUM_PORTS][MAX_REQ];
  logic [STRB_WIDTH-1:0] rq_strb  [NUM_PORTS][MAX_REQ];
  int unsigned           rq_cnt   [NUM_PORTS];
  int unsigned           rq_idx   [NUM_PORTS];

  int unsigned err_cnt    = 0;
  int unsigned chk_cnt    = 0;
  int unsigned ok_tests   = 0;
  int unsigned bad_tests  = 0;
  int unsigned cycle_cnt  = 0;
  bit          all_ready_chk = 1'b0;

  tcdm_cluster_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Monitor and reference model
  // --------------------------------------------------
  always @(posedge clk_i) begin : monitor
    int unsigned               grants [NUM_BANKS];
    logic [SEL_WIDTH-1:0]      bank;
    logic [MEM_ADDR_WIDTH-1:0] word;
    // Outputs are defined only once reset is released.
    if (arst_n_i === 1'b1) begin
      // Responses due from the previous cycle's handshakes.
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        chk_cnt++;
        assert (rsp_valid_o[p] === pend_vld[p]) else begin
          $display("error at %0t: port %0d rsp_valid %b, expected %b",
                   $time, p, rsp_valid_o[p], pend_vld[p]);
          err_cnt++;
        end
        if (pend_vld[p] && pend_chk[p]) begin
          chk_cnt++;
          assert (rsp_rdata_o[p] === pend_data[p]) else begin
            $display("error at %0t: port %0d rdata %h, expected %h",
                     $time, p, rsp_rdata_o[p], pend_data[p]);
            err_cnt++;
          end
        end
        pend_vld[p] = 1'b0;
      end
      // At most one ready per bank, and only to a valid port.
      for (int unsigned b = 0; b < NUM_BANKS; b++) grants[b] = 0;
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        bank = req_addr_i[p][BYTE_OFFSET +: SEL_WIDTH];
        if (req_ready_o[p] === 1'b1) grants[bank]++;
        assert (!(req_ready_o[p] === 1'b1 && req_valid_i[p] !== 1'b1)) else begin
          $display("error at %0t: port %0d ready without a request", $time, p);
          err_cnt++;
        end
      end
      for (int unsigned b = 0; b < NUM_BANKS; b++) begin
        assert (grants[b] <= 1) else begin
          $display("error at %0t: bank %0d granted %0d ports", $time, b, grants[b]);
          err_cnt++;
        end
      end
      // New handshakes read the old word, then writes update it.
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        bank = req_addr_i[p][BYTE_OFFSET +: SEL_WIDTH];
        word = req_addr_i[p][MEM_ADDR_LSB +: MEM_ADDR_WIDTH];
        if (req_valid_i[p] && req_ready_o[p]) begin
          pend_vld[p]  = 1'b1;
          pend_chk[p]  = model_known[bank][word];
          pend_data[p] = model_mem[bank][word];
          wait_cnt[p]  = 0;
          if (req_op_i[p] == OP_WRITE) begin
            for (int unsigned i = 0; i < STRB_WIDTH; i++) begin
              if (req_strb_i[p][i]) begin
                model_mem[bank][word][8*i +: 8] = req_wdata_i[p][8*i +: 8];
              end
            end
            if (req_strb_i[p] == '1) model_known[bank][word] = 1'b1;
          end
        end else if (req_valid_i[p]) begin
          // Grants that other ports took while this one waited.
          wait_cnt[p] = wait_cnt[p] + grants[bank];
          assert (wait_cnt[p] <= NUM_PORTS - 1) else begin
            $display("error at %0t: port %0d waited %0d grants", $time, p, wait_cnt[p]);
            err_cnt++;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return {~addr[15:0], addr[15:0]} ^ {addr[31:16], 16'h3c5a};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] bank_addr(input int unsigned bank,
                                                       input int unsigned word);
    return ADDR_WIDTH'((word << MEM_ADDR_LSB) | (bank << BYTE_OFFSET));
  endfunction

  task automatic push_req(input int unsigned p, input logic [ADDR_WIDTH-1:0] addr,
                          input tcdm_op_e op, input logic [DATA_WIDTH-1:0] wdata,
                          input logic [STRB_WIDTH-1:0] strb);
    rq_addr[p][rq_cnt[p]]  = addr;
    rq_op[p][rq_cnt[p]]    = op;
    rq_wdata[p][rq_cnt[p]] = wdata;
    rq_strb[p][rq_cnt[p]]  = strb;
    rq_cnt[p]++;
  endtask

  // Issues every list back to back, holding a request until it is accepted.
  task automatic run_requests();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      busy = 1'b0;
      if (all_ready_chk && req_valid_i == '1) begin
        chk_cnt++;
        assert (req_ready_o == '1) else begin
          $display("error at %0t: ports on distinct banks not all accepted, ready %b",
                   $time, req_ready_o);
          err_cnt++;
        end
      end
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        if (req_valid_i[p] && req_ready_o[p]) rq_idx[p]++;
        if (rq_idx[p] < rq_cnt[p]) begin
          busy = 1'b1;
          req_valid_i[p] <= 1'b1;
          req_addr_i[p]  <= rq_addr[p][rq_idx[p]];
          req_op_i[p]    <= rq_op[p][rq_idx[p]];
          req_wdata_i[p] <= rq_wdata[p][rq_idx[p]];
          req_strb_i[p]  <= rq_strb[p][rq_idx[p]];
        end else begin
          req_valid_i[p] <= 1'b0;
        end
      end
    end
    // Let the last responses come back.
    repeat (2) @(posedge clk_i);
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      rq_cnt[p] = 0;
      rq_idx[p] = 0;
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    if (err_cnt == err_before) begin
      ok_tests++;
      $display("test %s: ok", name);
    end else begin
      bad_tests++;
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    int unsigned           err_before;
    int unsigned           bank;
    int unsigned           word;
    logic [ADDR_WIDTH-1:0] addr;
    void'($urandom(SEED));
    arst_n_i    = 1'b0;
    req_valid_i = '0;
    req_addr_i  = '0;
    req_op_i    = {NUM_PORTS{OP_READ}};
    req_wdata_i = '0;
    req_strb_i  = '0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      rq_cnt[p] = 0;
      rq_idx[p] = 0;
    end
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Port p fills every word of bank p.
    // Responses stay low until the first handshake.
    err_before = err_cnt;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      for (int unsigned w = 0; w < BANK_WORDS; w++) begin
        addr = bank_addr(p, w);
        push_req(p, addr, OP_WRITE, fill_word(addr), '1);
      end
    end
    run_requests();
    report_test("reset and fill", err_before);

    // Full write, partial write, then read back on each bank.
    err_before = err_cnt;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      addr = bank_addr(p, $urandom_range(BANK_WORDS - 1, 0));
      push_req(p, addr, OP_WRITE, $urandom(), 4'b1111);
      push_req(p, addr, OP_WRITE, $urandom(), 4'b0101 << (p % 2));
      push_req(p, addr, OP_READ, '0, '0);
    end
    run_requests();
    report_test("write read strobes", err_before);

    // All ports on one bank.
    err_before = err_cnt;
    bank = $urandom_range(NUM_BANKS - 1, 0);
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      for (int unsigned i = 0; i < 8; i++) begin
        word = $urandom_range(BANK_WORDS - 1, 0);
        push_req(p, bank_addr(bank, word), tcdm_op_e'($urandom_range(1, 0)),
                 $urandom(), $urandom_range(15, 0));
      end
    end
    run_requests();
    report_test("bank conflict", err_before);

    // Writes to consecutive words and then reads of the same words.
    // Ports rotate over the banks so each bank answers several ports.
    err_before = err_cnt;
    all_ready_chk = 1'b1;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      for (int unsigned r = 0; r < 8; r++) begin
        addr = ADDR_WIDTH'((((r % 4) * NUM_BANKS) + ((p + r) % NUM_BANKS)) << BYTE_OFFSET);
        if (r < 4) push_req(p, addr, OP_WRITE, $urandom(), '1);
        else push_req(p, addr, OP_READ, '0, '0);
      end
    end
    run_requests();
    all_ready_chk = 1'b0;
    report_test("interleave", err_before);

    // Random mix over the whole address space.
    err_before = err_cnt;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      for (int unsigned i = 0; i < 100; i++) begin
        push_req(p, $urandom(), tcdm_op_e'($urandom_range(1, 0)), $urandom(),
                 $urandom_range(15, 0));
      end
    end
    run_requests();
    report_test("random mix", err_before);

    $display("summary: %0d tests ok, %0d tests with errors, %0d checks, %0d errors",
             ok_tests, bad_tests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tcdm_cluster_top.f ====
common/tcdm_pkg.sv
common/tcdm_bus_if.sv
rtl/tcdm_bank.sv
tcdm_interconnect/tcdm_rsp_tracker.sv
tcdm_interconnect/tcdm_xbar_arb.sv
tcdm_interconnect/tcdm_interconnect.sv
rtl/tcdm_cluster_top.sv
verification/tb_tcdm_cluster_top.sv

// ==== Bender.yml ====
package:
  name: tcdm_cluster

sources:
  - common/tcdm_pkg.sv
  - common/tcdm_bus_if.sv
  - rtl/tcdm_bank.sv
  - tcdm_interconnect/tcdm_rsp_tracker.sv
  - tcdm_interconnect/tcdm_xbar_arb.sv
  - tcdm_interconnect/tcdm_interconnect.sv
  - rtl/tcdm_cluster_top.sv
  - target: test
    files:
      - verification/tb_tcdm_cluster_top.sv
